/* tb/decode_patterns.txt */
# test wr_en wr_reg wr_data instr rd_reg_1 rd_reg_2 | exp rd_data_1 rd_data_2 oprnd_2 sext_imm
# out_wr_reg ctrl_word(21b hex, port order) err halt; test is decimal, all others hex
1  0 0 0000 0800 0 1 0000 0000 0000 0000 0 00000 0 0
2  0 0 0000 0800 7 6 0000 0000 0000 0000 0 00000 0 0
3  1 1 1234 0800 1 2 1234 0000 0000 0000 0 00000 0 0
4  1 5 abcd 0800 4 5 0000 abcd abcd 0000 0 00000 0 0
5  0 0 0000 0800 5 1 abcd 1234 1234 0000 0 00000 0 0
6  0 0 0000 d80c 1 5 1234 abcd abcd 000c 3 18000 0 0
7  0 0 0000 d809 1 5 1234 abcd abcd 0009 2 1801a 0 0
8  0 0 0000 409e 1 5 1234 abcd fffe fffe 4 08000 0 0
9  0 0 0000 503f 1 5 1234 abcd 001f 001f 1 08020 0 0
10 0 0 0000 c680 1 5 1234 abcd ff80 ff80 6 09000 0 0
11 0 0 0000 2400 1 5 1234 abcd abcd fc00 0 00100 0 0
12 0 0 0000 3005 1 5 1234 abcd abcd 0005 7 08900 0 0
13 0 0 0000 68fe 1 5 1234 abcd abcd fffe 7 80080 0 0
14 0 0 0000 8003 1 5 1234 abcd 0003 0003 0 16000 0 0
15 0 0 0000 8844 1 5 1234 abcd 0004 0004 2 0a400 0 0
16 0 0 0000 e814 1 5 1234 abcd abcd fff4 5 38c01 0 0
17 0 0 0000 4861 1 5 1234 abcd 0001 0001 3 0801a 0 0
18 0 0 0000 1000 1 5 1234 abcd abcd 0000 0 00000 1 0
19 0 0 0000 0000 1 5 1234 abcd abcd 0000 0 00000 0 1
20 1 2 5555 0800 1 2 1234 5555 5555 0000 0 00000 0 0
21 0 0 0000 0800 2 4 5555 0000 0000 0000 0 00000 0 0

/* list.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/decode_ctrl_if.sv
rtl/control_unit.sv
rtl/sign_extender.sv
rtl/reg_file_bypass.sv
rtl/decode_stage.sv
tb/decode_checker.sv
tb/tb_decode.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_decode -o sim_decode
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_decode)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
else
    exit 1
fi

/* tb/tb_decode.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module tb_decode;

    localparam int MAX_VEC = 64;
    localparam int CLK_PERIOD = 100;

    logic               clk;
    logic               rst_n;
    logic [`DATA_W-1:0] instr;
    logic [`REG_W-1:0]  rd_reg_1;
    logic [`REG_W-1:0]  rd_reg_2;
    logic               in_wr_en;
    logic [`REG_W-1:0]  in_wr_reg;
    logic [`DATA_W-1:0] wr_data;

    logic [`DATA_W-1:0] rd_data_1, rd_data_2, oprnd_2, sext_imm;
    logic [1:0]         br_cnd_sel, set_sel;
    logic [2:0]         wr_sel, alu_op;
    logic [`REG_W-1:0]  out_wr_reg;
    logic has_rt, out_wr_en, mem_wr_en, mem_en, jmp_reg_instr, jmp_instr, br_instr;
    logic alu_inv_a, alu_inv_b, alu_cin, alu_sign, halt, err;

    // One row per vector, filled from the pattern file.
    int                 v_test  [MAX_VEC];
    logic               v_wr_en [MAX_VEC];
    logic [`REG_W-1:0]  v_wr_reg [MAX_VEC];
    logic [`DATA_W-1:0] v_wr_data [MAX_VEC];
    logic [`DATA_W-1:0] v_instr [MAX_VEC];
    logic [`REG_W-1:0]  v_rd_1 [MAX_VEC];
    logic [`REG_W-1:0]  v_rd_2 [MAX_VEC];
    logic [`DATA_W-1:0] v_e_rd1 [MAX_VEC];
    logic [`DATA_W-1:0] v_e_rd2 [MAX_VEC];
    logic [`DATA_W-1:0] v_e_op2 [MAX_VEC];
    logic [`DATA_W-1:0] v_e_imm [MAX_VEC];
    logic [`REG_W-1:0]  v_e_wreg [MAX_VEC];
    logic [20:0]        v_e_ctrl [MAX_VEC];
    logic               v_e_err [MAX_VEC];
    logic               v_e_halt [MAX_VEC];

    int                 n_vec;
    logic               load_done;
    logic               check_en;
    int                 cur_test;
    logic [`DATA_W-1:0] exp_rd1, exp_rd2, exp_op2, exp_imm;
    logic [`REG_W-1:0]  exp_wreg;
    logic [20:0]        exp_ctrl;
    logic               exp_err, exp_halt;
    int                 tests_run, tests_failed;

    decode_stage DUT (
        .clk (clk), .rst_n (rst_n), .instr (instr),
        .rd_reg_1 (rd_reg_1), .rd_reg_2 (rd_reg_2),
        .in_wr_en (in_wr_en), .in_wr_reg (in_wr_reg), .wr_data (wr_data),
        .rd_data_1 (rd_data_1), .rd_data_2 (rd_data_2),
        .oprnd_2 (oprnd_2), .sext_imm (sext_imm),
        .br_cnd_sel (br_cnd_sel), .set_sel (set_sel), .has_rt (has_rt),
        .out_wr_en (out_wr_en), .out_wr_reg (out_wr_reg),
        .mem_wr_en (mem_wr_en), .mem_en (mem_en), .wr_sel (wr_sel),
        .jmp_reg_instr (jmp_reg_instr), .jmp_instr (jmp_instr), .br_instr (br_instr),
        .alu_op (alu_op), .alu_inv_a (alu_inv_a), .alu_inv_b (alu_inv_b),
        .alu_cin (alu_cin), .alu_sign (alu_sign), .halt (halt), .err (err)
    );

    decode_checker u_checker (
        .clk (clk), .check_en (check_en), .test_num (cur_test),
        .exp_rd_data_1 (exp_rd1), .exp_rd_data_2 (exp_rd2),
        .exp_oprnd_2 (exp_op2), .exp_sext_imm (exp_imm),
        .exp_wr_reg (exp_wreg), .exp_ctrl (exp_ctrl),
        .exp_err (exp_err), .exp_halt (exp_halt),
        .rd_data_1 (rd_data_1), .rd_data_2 (rd_data_2),
        .oprnd_2 (oprnd_2), .sext_imm (sext_imm), .out_wr_reg (out_wr_reg),
        .ctrl_word ({br_cnd_sel, set_sel, has_rt, out_wr_en, mem_wr_en, mem_en,
                     wr_sel, jmp_reg_instr, jmp_instr, br_instr,
                     alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign}),
        .err (err), .halt (halt),
        .tests_run (tests_run), .tests_failed (tests_failed)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run length scales with the number of vectors read.
    initial begin
        wait (load_done);
        #((n_vec + 10) * CLK_PERIOD);
        $display("Timeout: the checker did not see every vector before the time limit");
        $display("TEST FAIL");
        $finish;
    end

    task automatic read_patterns(output logic ok);
        int    fd;
        int    code;
        string line;
        ok    = 1'b0;
        n_vec = 0;
        fd    = $fopen("tb/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/decode_patterns.txt");
        end else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line[0] != "#") begin
                    code = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   v_test[n_vec], v_wr_en[n_vec], v_wr_reg[n_vec],
                                   v_wr_data[n_vec], v_instr[n_vec], v_rd_1[n_vec],
                                   v_rd_2[n_vec], v_e_rd1[n_vec], v_e_rd2[n_vec],
                                   v_e_op2[n_vec], v_e_imm[n_vec], v_e_wreg[n_vec],
                                   v_e_ctrl[n_vec], v_e_err[n_vec], v_e_halt[n_vec]);
                    if (code == 15) begin
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            ok = (n_vec > 0);
            if (!ok) begin
                $display("The pattern file holds no complete vector");
            end
        end
    endtask

    initial begin
        logic file_ok;
        rst_n     = 1'b0;
        instr     = 16'h0800;                // NOP.
        rd_reg_1  = '0;
        rd_reg_2  = '0;
        in_wr_en  = 1'b0;
        in_wr_reg = '0;
        wr_data   = '0;
        check_en  = 1'b0;
        cur_test  = 0;
        exp_rd1   = '0;
        exp_rd2   = '0;
        exp_op2   = '0;
        exp_imm   = '0;
        exp_wreg  = '0;
        exp_ctrl  = '0;
        exp_err   = 1'b0;
        exp_halt  = 1'b0;
        load_done = 1'b0;

        read_patterns(file_ok);
        load_done = 1'b1;
        if (!file_ok) begin
            $display("TEST FAIL");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_vec; i++) begin
                if (i > 0) begin
                    @(negedge clk);
                end
                in_wr_en  = v_wr_en[i];
                in_wr_reg = v_wr_reg[i];
                wr_data   = v_wr_data[i];
                instr     = v_instr[i];
                rd_reg_1  = v_rd_1[i];
                rd_reg_2  = v_rd_2[i];
                cur_test  = v_test[i];
                exp_rd1   = v_e_rd1[i];
                exp_rd2   = v_e_rd2[i];
                exp_op2   = v_e_op2[i];
                exp_imm   = v_e_imm[i];
                exp_wreg  = v_e_wreg[i];
                exp_ctrl  = v_e_ctrl[i];
                exp_err   = v_e_err[i];
                exp_halt  = v_e_halt[i];
                check_en  = 1'b1;
            end
            @(negedge clk);
            check_en = 1'b0;
            in_wr_en = 1'b0;
            wait (tests_run == n_vec);
            $display("tests run: %0d, failed: %0d", tests_run, tests_failed);
            if (tests_failed == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

/* tb/decode_checker.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_checker (
    input  logic               clk,
    input  logic               check_en,
    input  int                 test_num,
    input  logic [`DATA_W-1:0] exp_rd_data_1,
    input  logic [`DATA_W-1:0] exp_rd_data_2,
    input  logic [`DATA_W-1:0] exp_oprnd_2,
    input  logic [`DATA_W-1:0] exp_sext_imm,
    input  logic [`REG_W-1:0]  exp_wr_reg,
    input  logic [20:0]        exp_ctrl,
    input  logic               exp_err,
    input  logic               exp_halt,
    input  logic [`DATA_W-1:0] rd_data_1,
    input  logic [`DATA_W-1:0] rd_data_2,
    input  logic [`DATA_W-1:0] oprnd_2,
    input  logic [`DATA_W-1:0] sext_imm,
    input  logic [`REG_W-1:0]  out_wr_reg,
    input  logic [20:0]        ctrl_word,    // Control outputs packed in port order.
    input  logic               err,
    input  logic               halt,
    output int                 tests_run,
    output int                 tests_failed
);

    int field_errs;

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        field_errs   = 0;
    end

    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("MISMATCH time=%0t test=%0d signal=%s expected=%h actual=%h",
                     $time, test_num, name, exp_v, act_v);
            field_errs++;
        end
    endtask

    // Outputs settled since the falling edge, sampled before the register update.
    always @(posedge clk) begin
        if (check_en) begin
            field_errs = 0;
            check_field("rd_data_1", 32'(exp_rd_data_1), 32'(rd_data_1));
            check_field("rd_data_2", 32'(exp_rd_data_2), 32'(rd_data_2));
            check_field("oprnd_2", 32'(exp_oprnd_2), 32'(oprnd_2));
            check_field("sext_imm", 32'(exp_sext_imm), 32'(sext_imm));
            check_field("out_wr_reg", 32'(exp_wr_reg), 32'(out_wr_reg));
            check_field("ctrl_word", 32'(exp_ctrl), 32'(ctrl_word));
            check_field("err", 32'(exp_err), 32'(err));
            check_field("halt", 32'(exp_halt), 32'(halt));
            if (field_errs == 0) begin
                $display("test %0d: ok", test_num);
            end else begin
                $display("test %0d: failed with %0d wrong fields", test_num, field_errs);
                tests_failed = tests_failed + 1;
            end
            tests_run = tests_run + 1;
        end
    end

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`REG_W-1:0]  rd_reg_1,
    input  logic [`REG_W-1:0]  rd_reg_2,
    input  logic               in_wr_en,
    input  logic [`REG_W-1:0]  in_wr_reg,
    input  logic [`DATA_W-1:0] wr_data,
    output logic [`DATA_W-1:0] rd_data_1,
    output logic [`DATA_W-1:0] rd_data_2,
    output logic [`DATA_W-1:0] oprnd_2,
    output logic [`DATA_W-1:0] sext_imm,
    output logic [1:0]         br_cnd_sel,
    output logic [1:0]         set_sel,
    output logic               has_rt,
    output logic               out_wr_en,
    output logic [`REG_W-1:0]  out_wr_reg,
    output logic               mem_wr_en,
    output logic               mem_en,
    output logic [2:0]         wr_sel,
    output logic               jmp_reg_instr,
    output logic               jmp_instr,
    output logic               br_instr,
    output logic [2:0]         alu_op,
    output logic               alu_inv_a,
    output logic               alu_inv_b,
    output logic               alu_cin,
    output logic               alu_sign,
    output logic               halt,
    output logic               err
);
    import decode_pkg::*;

    decode_ctrl_if ctrl_bus ();

    control_unit u_control (
        .instr (instr),
        .ctrl  (ctrl_bus.ctrl)
    );

    sign_extender u_sext (
        .instr   (instr),
        .ext_sel (ctrl_bus.ext_sel),
        .imm     (sext_imm)
    );

    reg_file_bypass u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_reg_1  (rd_reg_1),
        .rd_reg_2  (rd_reg_2),
        .wr_en     (in_wr_en),
        .wr_reg    (in_wr_reg),
        .wr_data   (wr_data),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2)
    );

    // Destination field depends on the instruction format.
    always_comb begin
        case (ctrl_bus.dst_sel)
            DST_RD_R:  out_wr_reg = instr[4:2];
            DST_RD_I1: out_wr_reg = instr[7:5];
            DST_RS_I2: out_wr_reg = instr[10:8];
            default:   out_wr_reg = `LINK_REG;
        endcase
    end

    assign oprnd_2 = ctrl_bus.imm_op_sel ? sext_imm : rd_data_2;

    assign br_cnd_sel    = ctrl_bus.br_cnd_sel;
    assign set_sel       = ctrl_bus.set_sel;
    assign has_rt        = ctrl_bus.has_rt;
    assign out_wr_en     = ctrl_bus.wr_en;
    assign mem_wr_en     = ctrl_bus.mem_wr_en;
    assign mem_en        = ctrl_bus.mem_en;
    assign wr_sel        = ctrl_bus.wr_sel;
    assign jmp_reg_instr = ctrl_bus.jmp_reg_instr;
    assign jmp_instr     = ctrl_bus.jmp_instr;
    assign br_instr      = ctrl_bus.br_instr;
    assign alu_op        = ctrl_bus.alu_op;
    assign alu_inv_a     = ctrl_bus.alu_inv_a;
    assign alu_inv_b     = ctrl_bus.alu_inv_b;
    assign alu_cin       = ctrl_bus.alu_cin;
    assign alu_sign      = ctrl_bus.alu_sign;
    assign halt          = ctrl_bus.halt;
    assign err           = ctrl_bus.err;   // Illegal opcode only.

endmodule

/* rtl/reg_file_bypass.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module reg_file_bypass (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [`REG_W-1:0] rd_reg_1,
    input  logic [`REG_W-1:0] rd_reg_2,
    input  logic              wr_en,
    input  logic [`REG_W-1:0] wr_reg,
    input  logic [`DATA_W-1:0] wr_data,
    output logic [`DATA_W-1:0] rd_data_1,
    output logic [`DATA_W-1:0] rd_data_2
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // Forward the incoming write so the reader sees it this cycle.
    assign rd_data_1 = (wr_en && (wr_reg == rd_reg_1)) ? wr_data : regs[rd_reg_1];
    assign rd_data_2 = (wr_en && (wr_reg == rd_reg_2)) ? wr_data : regs[rd_reg_2];

endmodule

/* rtl/sign_extender.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module sign_extender (
    input  logic [`DATA_W-1:0] instr,
    input  decode_pkg::ext_op_t ext_sel,
    output logic [`DATA_W-1:0] imm
);
    import decode_pkg::*;

    always_comb begin
        case (ext_sel)
            EXT_SEXT5:  imm = {{(`DATA_W-5){instr[4]}}, instr[4:0]};
            EXT_ZEXT5:  imm = {{(`DATA_W-5){1'b0}}, instr[4:0]};
            EXT_SEXT8:  imm = {{(`DATA_W-8){instr[7]}}, instr[7:0]};   // I2 format.
            EXT_SEXT11: imm = {{(`DATA_W-11){instr[10]}}, instr[10:0]}; // Jump displacement.
            default:    imm = '0;
        endcase
    end

endmodule

/* rtl/control_unit.sv */
`timescale 1ns/1ps
`include "decode_macros.svh"

module control_unit (
    input  logic [`DATA_W-1:0] instr,
    decode_ctrl_if.ctrl        ctrl
);
    import decode_pkg::*;

    opcode_t opcode;
    alu_op_t r_func;

    assign opcode = opcode_t'(instr[15:11]);
    assign r_func = alu_op_t'({~instr[11], instr[1:0]});  // Bit 11 picks the arithmetic group.

    always_comb begin
        // Inactive bundle, overridden per opcode below.
        ctrl.br_cnd_sel    = BR_EQZ;
        ctrl.set_sel       = SET_SEQ;
        ctrl.has_rt        = 1'b0;
        ctrl.wr_en         = 1'b0;
        ctrl.mem_wr_en     = 1'b0;
        ctrl.mem_en        = 1'b0;
        ctrl.wr_sel        = WB_ALU;
        ctrl.jmp_reg_instr = 1'b0;
        ctrl.jmp_instr     = 1'b0;
        ctrl.br_instr      = 1'b0;
        ctrl.alu_op        = ALU_ADD;
        ctrl.alu_inv_a     = 1'b0;
        ctrl.alu_inv_b     = 1'b0;
        ctrl.alu_cin       = 1'b0;
        ctrl.alu_sign      = 1'b0;
        ctrl.halt          = 1'b0;
        ctrl.err           = 1'b0;
        ctrl.ext_sel       = EXT_SEXT5;
        ctrl.dst_sel       = DST_RD_R;
        ctrl.imm_op_sel    = 1'b0;

        case (opcode)
            OP_HALT: ctrl.halt = 1'b1;
            OP_NOP: ;
            OP_J: begin
                ctrl.jmp_instr = 1'b1;
                ctrl.ext_sel   = EXT_SEXT11;
            end
            OP_JR: begin
                ctrl.jmp_reg_instr = 1'b1;
                ctrl.ext_sel       = EXT_SEXT8;
                ctrl.imm_op_sel    = 1'b1;            // Target is Rs plus offset.
            end
            OP_JAL: begin
                ctrl.jmp_instr = 1'b1;
                ctrl.ext_sel   = EXT_SEXT11;
                ctrl.wr_en     = 1'b1;
                ctrl.dst_sel   = DST_LINK;
                ctrl.wr_sel    = WB_PC_NEXT;
            end
            OP_JALR: begin
                ctrl.jmp_reg_instr = 1'b1;
                ctrl.ext_sel       = EXT_SEXT8;
                ctrl.imm_op_sel    = 1'b1;
                ctrl.wr_en         = 1'b1;
                ctrl.dst_sel       = DST_LINK;
                ctrl.wr_sel        = WB_PC_NEXT;
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                ctrl.wr_en      = 1'b1;
                ctrl.dst_sel    = DST_RD_I1;
                ctrl.imm_op_sel = 1'b1;
                ctrl.ext_sel    = instr[12] ? EXT_ZEXT5 : EXT_SEXT5;  // Logic ops zero-extend.
                ctrl.alu_op     = alu_op_t'({1'b0, instr[12:11]});
                ctrl.alu_inv_a  = (opcode == OP_SUBI);
                ctrl.alu_cin    = (opcode == OP_SUBI);
                ctrl.alu_inv_b  = (opcode == OP_ANDNI);
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
                ctrl.br_instr   = 1'b1;
                ctrl.br_cnd_sel = br_cnd_t'(instr[12:11]);
                ctrl.ext_sel    = EXT_SEXT8;
            end
            OP_ST: begin
                ctrl.mem_en     = 1'b1;
                ctrl.mem_wr_en  = 1'b1;
                ctrl.has_rt     = 1'b1;               // Store data comes from read port 2.
                ctrl.imm_op_sel = 1'b1;
            end
            OP_LD: begin
                ctrl.mem_en     = 1'b1;
                ctrl.wr_en      = 1'b1;
                ctrl.dst_sel    = DST_RD_I1;
                ctrl.wr_sel     = WB_MEM;
                ctrl.imm_op_sel = 1'b1;
            end
            OP_SLBI: begin
                ctrl.wr_en      = 1'b1;
                ctrl.dst_sel    = DST_RS_I2;
                ctrl.wr_sel     = WB_SLBI;
                ctrl.ext_sel    = EXT_SEXT8;
                ctrl.imm_op_sel = 1'b1;
            end
            OP_LBI: begin
                ctrl.wr_en      = 1'b1;
                ctrl.dst_sel    = DST_RS_I2;
                ctrl.wr_sel     = WB_IMM;
                ctrl.ext_sel    = EXT_SEXT8;
                ctrl.imm_op_sel = 1'b1;
            end
            OP_ALU_R: begin
                ctrl.wr_en     = 1'b1;
                ctrl.has_rt    = 1'b1;
                ctrl.alu_op    = r_func;
                ctrl.alu_inv_a = (r_func == ALU_SUB);
                ctrl.alu_cin   = (r_func == ALU_SUB);
                ctrl.alu_inv_b = (r_func == ALU_ANDN);
            end
            OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
                ctrl.wr_en    = 1'b1;
                ctrl.has_rt   = 1'b1;
                ctrl.wr_sel   = WB_SET_FLAG;
                ctrl.set_sel  = set_cnd_t'(instr[12:11]);
                ctrl.alu_sign = (opcode == OP_SLT) || (opcode == OP_SLE);  // Signed compares.
            end
            default: ctrl.err = 1'b1;                 // Enables stay low.
        endcase
    end

endmodule

/* rtl/decode_ctrl_if.sv */
`timescale 1ns/1ps

interface decode_ctrl_if;
    import decode_pkg::*;

    br_cnd_t  br_cnd_sel;
    set_cnd_t set_sel;
    logic     has_rt;          // Instruction reads a second source register.
    logic     wr_en;
    logic     mem_wr_en;
    logic     mem_en;
    wb_sel_t  wr_sel;
    logic     jmp_reg_instr;
    logic     jmp_instr;
    logic     br_instr;
    alu_op_t  alu_op;
    logic     alu_inv_a;
    logic     alu_inv_b;
    logic     alu_cin;
    logic     alu_sign;
    logic     halt;
    logic     err;             // Illegal opcode.
    ext_op_t  ext_sel;
    dst_sel_t dst_sel;
    logic     imm_op_sel;      // Immediate replaces register as operand 2.

    modport ctrl (
        output br_cnd_sel, set_sel, has_rt, wr_en, mem_wr_en, mem_en, wr_sel,
        output jmp_reg_instr, jmp_instr, br_instr,
        output alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign,
        output halt, err, ext_sel, dst_sel, imm_op_sel
    );

    modport user (
        input br_cnd_sel, set_sel, has_rt, wr_en, mem_wr_en, mem_en, wr_sel,
        input jmp_reg_instr, jmp_instr, br_instr,
        input alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign,
        input halt, err, ext_sel, dst_sel, imm_op_sel
    );

endinterface

/* rtl/decode_pkg.sv */
package decode_pkg;

    // Primary opcode, instruction bits 15 to 11.
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JR    = 5'b00101,
        OP_JAL   = 5'b00110,
        OP_JALR  = 5'b00111,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_ST    = 5'b10000,
        OP_LD    = 5'b10001,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_ALU_R = 5'b11011,
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110,
        OP_SCO   = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN, ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL
    } alu_op_t;

    // Writeback source select.
    typedef enum logic [2:0] {
        WB_ALU, WB_MEM, WB_PC_NEXT, WB_SET_FLAG, WB_IMM, WB_SLBI
    } wb_sel_t;

    typedef enum logic [1:0] {
        EXT_SEXT5, EXT_ZEXT5, EXT_SEXT8, EXT_SEXT11
    } ext_op_t;

    // Destination register field.
    typedef enum logic [1:0] {
        DST_RD_R, DST_RD_I1, DST_RS_I2, DST_LINK
    } dst_sel_t;

    typedef enum logic [1:0] {
        BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ
    } br_cnd_t;

    typedef enum logic [1:0] {
        SET_SEQ, SET_SLT, SET_SLE, SET_SCO
    } set_cnd_t;

endpackage

/* rtl/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Word width of the datapath and of every instruction.
`define DATA_W 16

// Architectural register count.
`define REG_CNT 8

// Register-number width, enough to address REG_CNT entries.
`define REG_W 3

// Register written by JAL and JALR.
`define LINK_REG 3'd7

`endif
